//--- mips_pipe_pkg.sv
package mips_pipe_pkg;

	localparam int word_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int reg_count      = 1 << reg_addr_width;

	typedef logic [word_width-1:0]     word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	localparam word_t reset_pc = 32'h0000_0000;

	// ------------------------------------------------------------------------
	// Instruction encodings
	// ------------------------------------------------------------------------
	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_j     = 6'b000010,
		op_beq   = 6'b000100,
		op_bne   = 6'b000101,
		op_addi  = 6'b001000,
		op_addiu = 6'b001001,
		op_ori   = 6'b001101,
		op_lui   = 6'b001111,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		fn_add  = 6'b100000,
		fn_addu = 6'b100001,
		fn_sub  = 6'b100010,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_slt  = 6'b101010
	} funct_e;

	typedef enum logic [2:0] {
		alu_and,
		alu_or,
		alu_add,
		alu_sub,
		alu_slt
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;  // Load
		logic    mem_write;
		logic    branch;
		logic    branch_ne;   // BNE rather than BEQ
		logic    jump;
		logic    alu_src;     // Immediate as operand b
		logic    reg_dst;     // rd rather than rt
		logic    sign_ext;
		logic    shift_16;    // LUI
		alu_op_e alu_op;
	} ctrl_t;

endpackage

//--- mips_pipe_if.sv
interface id_ex_if import mips_pipe_pkg::*; ();

	ctrl_t     ctrl;
	word_t     pc_plus4;
	word_t     rs_val;
	word_t     rt_val;
	word_t     imm;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     target;     // Precomputed J target

	modport producer (output ctrl, pc_plus4, rs_val, rt_val, imm, rs, rt, rd, target);
	modport consumer (input ctrl, pc_plus4, rs_val, rt_val, imm, rs, rt, rd, target);

endinterface

interface ex_mem_if import mips_pipe_pkg::*; ();

	logic      reg_write;
	logic      mem_to_reg;
	logic      mem_write;
	word_t     alu_out;
	word_t     store_data;
	reg_addr_t dest;

	modport producer (output reg_write, mem_to_reg, mem_write, alu_out, store_data, dest);
	modport consumer (input reg_write, mem_to_reg, mem_write, alu_out, store_data, dest);

endinterface

interface wb_if import mips_pipe_pkg::*; ();

	logic      reg_write;
	reg_addr_t dest;
	word_t     result;

	modport producer (output reg_write, dest, result);
	modport consumer (input reg_write, dest, result);

endinterface

//--- fetch_stage.sv
module fetch_stage import mips_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  stall,
	input  logic  flush,
	input  logic  redirect,
	input  word_t redirect_pc,
	input  word_t instr,
	output word_t instr_addr,
	output word_t id_instr,
	output word_t id_pc_plus4
);

	word_t pc;
	word_t pc_plus4;

	assign pc_plus4   = pc + 32'd4;
	assign instr_addr = pc;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// All-zero word decodes as a no-op
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			id_instr <= '0;
		end else if (flush) begin
			id_instr <= '0;
		end else if (!stall) begin
			id_instr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc_plus4 <= pc_plus4;
		end
	end

endmodule

//--- decode_stage.sv
module decode_stage import mips_pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       stall,
	input  logic       flush,
	input  word_t      id_instr,
	input  word_t      id_pc_plus4,
	wb_if.consumer     wb,
	id_ex_if.producer  id_ex
);

	word_t     regs [reg_count];
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     rs_val;
	word_t     rt_val;
	word_t     imm;
	opcode_e   opcode;
	funct_e    funct;
	ctrl_t     dec_ctrl;

	assign rs     = id_instr[25:21];
	assign rt     = id_instr[20:16];
	assign rd     = id_instr[15:11];
	assign opcode = opcode_e'(id_instr[31:26]);
	assign funct  = funct_e'(id_instr[5:0]);

	// ------------------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wb.reg_write && wb.dest != '0) begin
			regs[wb.dest] <= wb.result;
		end
	end

	// Same-cycle writeback is passed straight through
	assign rs_val = (rs == '0) ? '0 :
		(wb.reg_write && wb.dest == rs) ? wb.result : regs[rs];
	assign rt_val = (rt == '0) ? '0 :
		(wb.reg_write && wb.dest == rt) ? wb.result : regs[rt];

	// ------------------------------------------------------------------------
	// Decoder
	// ------------------------------------------------------------------------
	always_comb begin
		dec_ctrl = '0;
		case (opcode)
			op_rtype: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.reg_dst   = 1'b1;
				case (funct)
					fn_add, fn_addu: dec_ctrl.alu_op = alu_add;
					fn_sub, fn_subu: dec_ctrl.alu_op = alu_sub;
					fn_and:          dec_ctrl.alu_op = alu_and;
					fn_or:           dec_ctrl.alu_op = alu_or;
					fn_slt:          dec_ctrl.alu_op = alu_slt;
					default:         dec_ctrl = '0;  // Includes the all-zero no-op
				endcase
			end
			op_lw: begin
				dec_ctrl.reg_write  = 1'b1;
				dec_ctrl.mem_to_reg = 1'b1;
				dec_ctrl.alu_src    = 1'b1;
				dec_ctrl.sign_ext   = 1'b1;
				dec_ctrl.alu_op     = alu_add;
			end
			op_sw: begin
				dec_ctrl.mem_write = 1'b1;
				dec_ctrl.alu_src   = 1'b1;
				dec_ctrl.sign_ext  = 1'b1;
				dec_ctrl.alu_op    = alu_add;
			end
			op_beq, op_bne: begin
				dec_ctrl.branch    = 1'b1;
				dec_ctrl.branch_ne = (opcode == op_bne);
				dec_ctrl.sign_ext  = 1'b1;
				dec_ctrl.alu_op    = alu_sub;
			end
			op_addi, op_addiu: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.alu_src   = 1'b1;
				dec_ctrl.sign_ext  = 1'b1;
				dec_ctrl.alu_op    = alu_add;
			end
			op_ori, op_lui: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.alu_src   = 1'b1;
				dec_ctrl.shift_16  = (opcode == op_lui);
				dec_ctrl.alu_op    = alu_or;  // LUI has rs = 0
			end
			op_j: dec_ctrl.jump = 1'b1;
			default: dec_ctrl = '0;
		endcase
	end

	assign imm = dec_ctrl.sign_ext ? {{16{id_instr[15]}}, id_instr[15:0]} :
		{16'b0, id_instr[15:0]};

	// ------------------------------------------------------------------------
	// Decode/execute register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			id_ex.ctrl <= '0;
		end else if (stall || flush) begin
			id_ex.ctrl <= '0;  // Bubble
		end else begin
			id_ex.ctrl <= dec_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.pc_plus4 <= id_pc_plus4;
		id_ex.rs_val   <= rs_val;
		id_ex.rt_val   <= rt_val;
		id_ex.imm      <= imm;
		id_ex.rs       <= rs;
		id_ex.rt       <= rt;
		id_ex.rd       <= rd;
		id_ex.target   <= {id_pc_plus4[31:28], id_instr[25:0], 2'b00};
	end

endmodule

//--- execute_stage.sv
module execute_stage import mips_pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  fwd_sel_e   fwd_a,
	input  fwd_sel_e   fwd_b,
	id_ex_if.consumer  id_ex,
	wb_if.consumer     wb,
	ex_mem_if.producer ex_mem,
	output logic       redirect,
	output word_t      redirect_pc
);

	word_t     op_a;
	word_t     op_b_reg;
	word_t     op_b;
	word_t     imm_val;
	word_t     alu_result;
	logic      operands_equal;
	logic      branch_taken;
	reg_addr_t dest;

	function automatic word_t pick_operand(fwd_sel_e sel, word_t reg_val, word_t mem_val,
		word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Operands and ALU
	// ------------------------------------------------------------------------
	assign op_a     = pick_operand(fwd_a, id_ex.rs_val, ex_mem.alu_out, wb.result);
	assign op_b_reg = pick_operand(fwd_b, id_ex.rt_val, ex_mem.alu_out, wb.result);
	assign imm_val  = id_ex.ctrl.shift_16 ? {id_ex.imm[15:0], 16'b0} : id_ex.imm;
	assign op_b     = id_ex.ctrl.alu_src ? imm_val : op_b_reg;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_and: alu_result = op_a & op_b;
			alu_or:  alu_result = op_a | op_b;
			alu_add: alu_result = op_a + op_b;
			alu_sub: alu_result = op_a - op_b;
			alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			default: alu_result = '0;
		endcase
	end

	// ------------------------------------------------------------------------
	// Branch and jump resolution
	// ------------------------------------------------------------------------
	assign operands_equal = (op_a == op_b_reg);
	assign branch_taken   = id_ex.ctrl.branch &&
		(id_ex.ctrl.branch_ne ? !operands_equal : operands_equal);
	assign redirect       = id_ex.ctrl.jump || branch_taken;
	assign redirect_pc    = id_ex.ctrl.jump ? id_ex.target :
		id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

	assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_mem.reg_write  <= 1'b0;
			ex_mem.mem_to_reg <= 1'b0;
			ex_mem.mem_write  <= 1'b0;
		end else begin
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem.alu_out    <= alu_result;
		ex_mem.store_data <= op_b_reg;  // Forwarded rt
		ex_mem.dest       <= dest;
	end

endmodule

//--- hazard_unit.sv
module hazard_unit import mips_pipe_pkg::*; (
	input  reg_addr_t  id_rs,
	input  reg_addr_t  id_rt,
	input  logic       redirect,
	id_ex_if.consumer  id_ex,
	ex_mem_if.consumer ex_mem,
	wb_if.consumer     wb,
	output logic       stall,
	output logic       flush,
	output fwd_sel_e   fwd_a,
	output fwd_sel_e   fwd_b
);

	logic load_in_ex;

	// Memory stage holds the younger result, so it wins
	function automatic fwd_sel_e pick_source(reg_addr_t src, logic mem_we, reg_addr_t mem_dst,
		logic wb_we, reg_addr_t wb_dst);
		if (mem_we && mem_dst != '0 && mem_dst == src) begin
			return fwd_mem;
		end else if (wb_we && wb_dst != '0 && wb_dst == src) begin
			return fwd_wb;
		end
		return fwd_reg;
	endfunction

	assign fwd_a = pick_source(id_ex.rs, ex_mem.reg_write, ex_mem.dest, wb.reg_write, wb.dest);
	assign fwd_b = pick_source(id_ex.rt, ex_mem.reg_write, ex_mem.dest, wb.reg_write, wb.dest);

	// Load result not ready until writeback
	assign load_in_ex = id_ex.ctrl.mem_to_reg && id_ex.rt != '0;
	assign stall      = load_in_ex && (id_ex.rt == id_rs || id_ex.rt == id_rt);

	assign flush = redirect;

endmodule

//--- mem_wb_stage.sv
module mem_wb_stage import mips_pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  word_t      data_rdata,
	ex_mem_if.consumer ex_mem,
	wb_if.producer     wb
);

	logic  mem_to_reg;
	word_t alu_q;
	word_t load_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb.reg_write <= 1'b0;
			mem_to_reg   <= 1'b0;
		end else begin
			wb.reg_write <= ex_mem.reg_write;
			mem_to_reg   <= ex_mem.mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		alu_q   <= ex_mem.alu_out;
		load_q  <= data_rdata;
		wb.dest <= ex_mem.dest;
	end

	assign wb.result = mem_to_reg ? load_q : alu_q;

endmodule

//--- mips_pipe.sv
module mips_pipe import mips_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  word_t instr,
	input  word_t data_rdata,
	output word_t instr_addr,
	output word_t data_addr,
	output word_t data_wdata,
	output logic  data_we
);

	word_t    id_instr;
	word_t    id_pc_plus4;
	logic     stall;
	logic     flush;
	logic     redirect;
	word_t    redirect_pc;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;

	id_ex_if  id_ex ();
	ex_mem_if ex_mem ();
	wb_if     wb ();

	fetch_stage fetch_i (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.flush       (flush),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.id_instr    (id_instr),
		.id_pc_plus4 (id_pc_plus4)
	);

	decode_stage decode_i (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.flush       (flush),
		.id_instr    (id_instr),
		.id_pc_plus4 (id_pc_plus4),
		.wb          (wb.consumer),
		.id_ex       (id_ex.producer)
	);

	hazard_unit hazard_i (
		.id_rs    (id_instr[25:21]),
		.id_rt    (id_instr[20:16]),
		.redirect (redirect),
		.id_ex    (id_ex.consumer),
		.ex_mem   (ex_mem.consumer),
		.wb       (wb.consumer),
		.stall    (stall),
		.flush    (flush),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b)
	);

	execute_stage execute_i (
		.clk         (clk),
		.reset       (reset),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.id_ex       (id_ex.consumer),
		.wb          (wb.consumer),
		.ex_mem      (ex_mem.producer),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	mem_wb_stage mem_wb_i (
		.clk        (clk),
		.reset      (reset),
		.data_rdata (data_rdata),
		.ex_mem     (ex_mem.consumer),
		.wb         (wb.producer)
	);

	// Data port comes straight off the execute/memory register
	assign data_addr  = ex_mem.alu_out;
	assign data_wdata = ex_mem.store_data;
	assign data_we    = ex_mem.mem_write;

endmodule

//--- tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len = 31;

task automatic load_program();
	word_t a;
	word_t b;
	word_t hi;
	word_t masked;
	a      = 32'd5;
	b      = a - 32'd12;
	hi     = (32'h1234 << 16) | 32'h567f;
	masked = hi & b;
	// Field order is rs, rt, then rd or immediate
	imem[0]  = i_type(op_addi, 0, 1, 5);
	imem[1]  = i_type(op_addi, 1, 2, -12);  // Distance one on r1
	imem[2]  = r_type(fn_add, 1, 2, 3);
	imem[3]  = i_type(op_sw, 0, 3, 0);
	imem[4]  = r_type(fn_sub, 1, 2, 4);
	imem[5]  = i_type(op_sw, 0, 4, 4);
	imem[6]  = r_type(fn_slt, 2, 1, 5);     // Negative against positive
	imem[7]  = i_type(op_sw, 0, 5, 8);
	imem[8]  = i_type(op_lui, 0, 6, 'h1234);
	imem[9]  = i_type(op_ori, 6, 6, 'h567f);
	imem[10] = r_type(fn_and, 6, 2, 7);
	imem[11] = r_type(fn_or, 7, 1, 8);
	imem[12] = i_type(op_sw, 0, 8, 12);
	imem[13] = i_type(op_addi, 0, 0, 9);    // Write to r0 is dropped
	imem[14] = i_type(op_sw, 0, 0, 16);
	imem[15] = i_type(op_lw, 0, 9, 128);
	imem[16] = r_type(fn_add, 9, 1, 10);    // Load-use
	imem[17] = i_type(op_sw, 0, 10, 20);
	imem[18] = i_type(op_beq, 1, 1, 2);     // Taken
	imem[19] = i_type(op_sw, 0, 1, 24);
	imem[20] = i_type(op_sw, 0, 1, 28);
	imem[21] = i_type(op_beq, 1, 2, 2);     // Not taken
	imem[22] = i_type(op_sw, 0, 6, 24);
	imem[23] = i_type(op_bne, 1, 2, 2);     // Taken
	imem[24] = i_type(op_sw, 0, 1, 28);
	imem[25] = i_type(op_sw, 0, 1, 32);
	imem[26] = jump_to(29);
	imem[27] = i_type(op_sw, 0, 1, 36);
	imem[28] = i_type(op_sw, 0, 1, 40);
	imem[29] = i_type(op_sw, 0, 7, 28);
	imem[30] = jump_to(30);
	expect_store(32'd0, a + b);
	expect_store(32'd4, a - b);
	expect_store(32'd8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
	expect_store(32'd12, masked | a);
	expect_store(32'd16, 32'd0);
	expect_store(32'd20, dmem[32] + a);     // Word 32 holds the random load operand
	expect_store(32'd24, hi);
	expect_store(32'd28, masked);
endtask

`endif

//--- tb_mips_pipe.sv
module tb_mips_pipe import mips_pipe_pkg::*; ();

	localparam int clk_period   = 8;
	localparam int reset_cycles = 10;
	localparam int quiet_cycles = 20;
	localparam int mem_words    = 64;

	logic  clk;
	logic  reset;
	word_t instr;
	word_t data_rdata;
	word_t instr_addr;
	word_t data_addr;
	word_t data_wdata;
	logic  data_we;

	word_t imem [mem_words];
	word_t dmem [mem_words];
	word_t store_addr_q [$];
	word_t store_data_q [$];

	mips_pipe dut_i (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.data_rdata (data_rdata),
		.instr_addr (instr_addr),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_we    (data_we)
	);

	// ------------------------------------------------------------------------
	// Instruction encoding and the expected store list
	// ------------------------------------------------------------------------
	function automatic word_t r_type(funct_e fn, int rs, int rt, int rd);
		return {op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'b00000, fn};
	endfunction

	function automatic word_t i_type(opcode_e op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic word_t jump_to(int index);
		return {op_j, index[25:0]};
	endfunction

	task automatic expect_store(word_t addr, word_t data);
		store_addr_q.push_back(addr);
		store_data_q.push_back(data);
	endtask

	task automatic fail_run();
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	`include "tb_program.svh"

	task automatic check_store();
		word_t exp_addr;
		word_t exp_data;
		assert (store_addr_q.size() > 0) else begin
			$display("Unexpected store at time %0t to address %h", $time, data_addr);
			fail_run();
		end
		exp_addr = store_addr_q.pop_front();
		exp_data = store_data_q.pop_front();
		assert (data_addr == exp_addr) else begin
			$display("MISMATCH time=%0t data_addr expected=%h actual=%h",
				$time, exp_addr, data_addr);
			fail_run();
		end
		assert (data_wdata == exp_data) else begin
			$display("MISMATCH time=%0t data_wdata expected=%h actual=%h",
				$time, exp_data, data_wdata);
			fail_run();
		end
		dmem[data_addr[7:2]] = data_wdata;
	endtask

	// ------------------------------------------------------------------------
	// Clock, memories and checks
	// ------------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Both memories answer the current addresses, refreshed each falling edge
	always @(negedge clk) begin
		if (!reset && data_we) begin
			check_store();
		end
		instr      <= imem[instr_addr[7:2]];
		data_rdata <= dmem[data_addr[7:2]];
	end

	always @(posedge clk) begin
		if (reset) begin
			assert (data_we === 1'b0) else begin
				$display("MISMATCH time=%0t data_we expected=0 actual=%b", $time, data_we);
				fail_run();
			end
			assert (instr_addr === reset_pc) else begin
				$display("MISMATCH time=%0t instr_addr expected=%h actual=%h",
					$time, reset_pc, instr_addr);
				fail_run();
			end
		end
	end

	initial begin
		#((reset_cycles + 20 * prog_len) * clk_period);
		$display("Timeout at time %0t with %0d stores still expected", $time,
			store_addr_q.size());
		fail_run();
	end

	initial begin
		reset      = 1'b1;
		instr      = '0;
		data_rdata = '0;
		void'($urandom(25));
		for (int i = 0; i < mem_words; i++) begin
			imem[i] = '0;  // No-op
			dmem[i] = $urandom();
		end
		load_program();
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		while (store_addr_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (quiet_cycles) @(negedge clk);  // Any store now is an extra one
		$display("Test passed");
		$finish;
	end

endmodule

//--- mips_pipe.f
+incdir+.
mips_pipe_pkg.sv
mips_pipe_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
hazard_unit.sv
mem_wb_stage.sv
mips_pipe.sv
tb_mips_pipe.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mips_pipe -f mips_pipe.f -o tb_mips_pipe \
	&& ./obj_dir/tb_mips_pipe > sim.log 2>&1
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
